//--- logic/axil_pkg.sv
`include "cache_macros.svh"

package axil_pkg;

  // Byte address on either side of the cache
  typedef logic [`ADDR_W-1:0] addr_t;

  // One data word
  typedef logic [`DATA_W-1:0] data_t;

  // One enable bit per byte lane
  typedef logic [`STRB_W-1:0] strb_t;

endpackage

//--- logic/backing_mem.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module backing_mem
  import axil_pkg::*;
(
  input  logic  ACLK,
  input  logic  ARESETn,
  input  logic  mem_arvalid,
  output logic  mem_arready,
  input  addr_t mem_araddr,
  output logic  mem_rvalid,
  output data_t mem_rdata,
  input  logic  mem_awvalid,
  output logic  mem_awready,
  input  addr_t mem_awaddr,
  input  logic  mem_wvalid,
  output logic  mem_wready,
  input  data_t mem_wdata,
  output logic  mem_bvalid
);

  localparam int mem_aw = $clog2(`MEM_WORDS);

  data_t mem_array [`MEM_WORDS];

  logic rd_fire;
  logic wr_fire;

  // Contents start cleared
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem_array[i] = '0;
    end
  end

  // Never stalls
  assign mem_arready = 1'b1;
  assign mem_awready = 1'b1;
  assign mem_wready  = 1'b1;

  assign rd_fire = mem_arvalid && mem_arready;
  assign wr_fire = mem_awvalid && mem_awready && mem_wvalid && mem_wready;

  always_ff @(posedge ACLK) begin
    if (rd_fire) begin
      mem_rdata <= mem_array[mem_araddr[`OFFSET_BITS +: mem_aw]];
    end
    if (wr_fire) begin
      mem_array[mem_awaddr[`OFFSET_BITS +: mem_aw]] <= mem_wdata;
    end
  end

  // Responses are single-cycle pulses
  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      mem_rvalid <= 1'b0;
      mem_bvalid <= 1'b0;
    end else begin
      mem_rvalid <= rd_fire;
      mem_bvalid <= wr_fire;
    end
  end

endmodule

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
  import axil_pkg::*;
  import cache_pkg::*;
(
  input  logic  ACLK,
  input  logic  ARESETn,

  // Processor side
  input  logic  arvalid,
  output logic  arready,
  input  addr_t araddr,
  output logic  rvalid,
  input  logic  rready,
  output data_t rdata,
  input  logic  awvalid,
  output logic  awready,
  input  addr_t awaddr,
  input  logic  wvalid,
  output logic  wready,
  input  data_t wdata,
  input  strb_t wstrb,
  output logic  bvalid,
  input  logic  bready,

  // Memory side
  output logic  mem_arvalid,
  input  logic  mem_arready,
  output addr_t mem_araddr,
  input  logic  mem_rvalid,
  input  data_t mem_rdata,
  output logic  mem_awvalid,
  input  logic  mem_awready,
  output addr_t mem_awaddr,
  output logic  mem_wvalid,
  input  logic  mem_wready,
  output data_t mem_wdata,
  input  logic  mem_bvalid,

  // Store side
  output addr_t lookup_addr,
  input  logic  hit,
  input  logic  victim_dirty,
  input  addr_t victim_addr,
  input  data_t line_data,
  output logic  fill_en,
  output data_t fill_data,
  output logic  write_en,
  output data_t write_data,
  output strb_t write_strb
);

  cache_state_t state, state_d;

  addr_t miss_addr;
  logic  miss_is_read;
  data_t miss_wdata;
  strb_t miss_wstrb;

  logic ar_fire;
  logic w_fire;
  logic mem_ar_fire;
  logic mem_aw_fire;
  logic rsp_done;
  logic miss_start;
  logic wb_start;
  logic fill_start;
  logic fill_done;

  assign arready = (state == AVAILABLE);
  assign awready = (state == AVAILABLE);
  assign wready  = (state == AVAILABLE);

  assign ar_fire     = arvalid && arready;
  assign w_fire      = awvalid && awready && wvalid && wready;
  assign mem_ar_fire = mem_arvalid && mem_arready;
  assign mem_aw_fire = mem_awvalid && mem_awready && mem_wvalid && mem_wready;
  assign rsp_done    = (rvalid && rready) || (bvalid && bready);

  assign miss_start = (ar_fire || w_fire) && !hit;
  assign wb_start   = miss_start && victim_dirty;
  // Straight to fill on a clean victim, or once the writeback is acknowledged
  assign fill_start = (miss_start && !victim_dirty) || (state == WRITEBACK && mem_bvalid);
  assign fill_done  = (state == FILL) && mem_rvalid;

  // Reads and writes never arrive together, so arvalid picks the address
  assign lookup_addr = (state == AVAILABLE) ? (arvalid ? araddr : awaddr) : miss_addr;

  assign fill_en    = fill_done;
  assign fill_data  = mem_rdata;
  assign write_en   = (w_fire && hit) || (fill_done && !miss_is_read);
  assign write_data = (state == AVAILABLE) ? wdata : miss_wdata;
  assign write_strb = (state == AVAILABLE) ? wstrb : miss_wstrb;

  always_comb begin
    state_d = state;
    case (state)
      AVAILABLE: begin
        if (ar_fire || w_fire) begin
          if (hit) begin
            state_d = RESPOND;
          end else if (victim_dirty) begin
            state_d = WRITEBACK;
          end else begin
            state_d = FILL;
          end
        end
      end
      WRITEBACK: begin
        if (mem_bvalid) begin
          state_d = FILL;
        end
      end
      FILL: begin
        if (mem_rvalid) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (rsp_done) begin
          state_d = AVAILABLE;
        end
      end
      default: state_d = AVAILABLE;
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state       <= AVAILABLE;
      rvalid      <= 1'b0;
      bvalid      <= 1'b0;
      mem_arvalid <= 1'b0;
      mem_awvalid <= 1'b0;
      mem_wvalid  <= 1'b0;
    end else begin
      state <= state_d;

      if ((ar_fire && hit) || (fill_done && miss_is_read)) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end

      if ((w_fire && hit) || (fill_done && !miss_is_read)) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end

      if (fill_start) begin
        mem_arvalid <= 1'b1;
      end else if (mem_ar_fire) begin
        mem_arvalid <= 1'b0;
      end

      // Address and data of the writeback travel together
      if (wb_start) begin
        mem_awvalid <= 1'b1;
        mem_wvalid  <= 1'b1;
      end else if (mem_aw_fire) begin
        mem_awvalid <= 1'b0;
        mem_wvalid  <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (ar_fire || w_fire) begin
      miss_addr    <= lookup_addr;
      miss_is_read <= ar_fire;
      miss_wdata   <= wdata;
      miss_wstrb   <= wstrb;
    end
    if (ar_fire && hit) begin
      rdata <= line_data;
    end else if (fill_done && miss_is_read) begin
      rdata <= mem_rdata;
    end
    // Victim word and its address as seen at acceptance
    if (wb_start) begin
      mem_awaddr <= victim_addr;
      mem_wdata  <= line_data;
    end
    if (fill_start) begin
      mem_araddr <= lookup_addr;
    end
  end

endmodule

//--- logic/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Bus widths seen by the processor and the memory
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4

// Byte offset inside a word
`define OFFSET_BITS 2

// Cache geometry, one word per set
`define NUM_SETS 4
`define INDEX_BITS 2

// Backing memory depth in words
`define MEM_WORDS 1024

`endif

//--- logic/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

  // Set selected by the address bits just above the byte offset
  typedef logic [`INDEX_BITS-1:0] index_t;

  // Everything above the index
  typedef logic [`ADDR_W-`INDEX_BITS-`OFFSET_BITS-1:0] tag_t;

  // Controller states
  typedef enum logic [1:0] {
    // Idle, takes new requests and answers hits
    AVAILABLE = 2'd0,
    // Dirty victim going out to memory
    WRITEBACK = 2'd1,
    // Waiting for the missed word from memory
    FILL      = 2'd2,
    // Response held until the manager takes it
    RESPOND   = 2'd3
  } cache_state_t;

endpackage

//--- logic/cache_store.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_store
  import axil_pkg::*;
  import cache_pkg::*;
(
  input  logic  ACLK,
  input  logic  ARESETn,
  input  addr_t lookup_addr,
  output logic  hit,
  output logic  victim_dirty,
  output addr_t victim_addr,
  output data_t line_data,
  input  logic  fill_en,
  input  data_t fill_data,
  input  logic  write_en,
  input  data_t wdata,
  input  strb_t wstrb
);

  tag_t   tag_q   [`NUM_SETS];
  data_t  data_q  [`NUM_SETS];
  logic   valid_q [`NUM_SETS];
  logic   dirty_q [`NUM_SETS];

  index_t lk_index;
  tag_t   lk_tag;
  data_t  base_word;

  // Byte lanes with a set strobe come from wd, the rest from base
  function automatic data_t merge_bytes(data_t base, data_t wd, strb_t st);
    data_t res;
    res = base;
    for (int b = 0; b < `STRB_W; b++) begin
      if (st[b]) begin
        res[8*b +: 8] = wd[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign lk_index = lookup_addr[`OFFSET_BITS +: `INDEX_BITS];
  assign lk_tag   = lookup_addr[`ADDR_W-1 : `OFFSET_BITS+`INDEX_BITS];

  assign hit          = valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
  assign victim_dirty = valid_q[lk_index] && dirty_q[lk_index];
  assign victim_addr  = {tag_q[lk_index], lk_index, {`OFFSET_BITS{1'b0}}};
  assign line_data    = data_q[lk_index];

  // A write during a fill merges over the incoming word
  assign base_word = fill_en ? fill_data : data_q[lk_index];

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        valid_q[s] <= 1'b0;
      end
    end else if (fill_en) begin
      valid_q[lk_index] <= 1'b1;
    end
  end

  always_ff @(posedge ACLK) begin
    if (fill_en) begin
      tag_q[lk_index] <= lk_tag;
    end
    if (fill_en || write_en) begin
      data_q[lk_index]  <= write_en ? merge_bytes(base_word, wdata, wstrb) : fill_data;
      // Clean after a plain fill, dirty after any write
      dirty_q[lk_index] <= write_en;
    end
  end

endmodule

//--- logic/cache_top.sv
`timescale 1ns/1ps

module cache_top
  import axil_pkg::*;
(
  input  logic  ACLK,
  input  logic  ARESETn,
  input  logic  arvalid,
  output logic  arready,
  input  addr_t araddr,
  output logic  rvalid,
  input  logic  rready,
  output data_t rdata,
  input  logic  awvalid,
  output logic  awready,
  input  addr_t awaddr,
  input  logic  wvalid,
  output logic  wready,
  input  data_t wdata,
  input  strb_t wstrb,
  output logic  bvalid,
  input  logic  bready
);

  // Controller to memory
  logic  mem_arvalid;
  logic  mem_arready;
  addr_t mem_araddr;
  logic  mem_rvalid;
  data_t mem_rdata;
  logic  mem_awvalid;
  logic  mem_awready;
  addr_t mem_awaddr;
  logic  mem_wvalid;
  logic  mem_wready;
  data_t mem_wdata;
  logic  mem_bvalid;

  // Controller to store
  addr_t lookup_addr;
  logic  hit;
  logic  victim_dirty;
  addr_t victim_addr;
  data_t line_data;
  logic  fill_en;
  data_t fill_data;
  logic  write_en;
  data_t write_data;
  strb_t write_strb;

  cache_ctrl u_ctrl (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .arvalid      (arvalid),
    .arready      (arready),
    .araddr       (araddr),
    .rvalid       (rvalid),
    .rready       (rready),
    .rdata        (rdata),
    .awvalid      (awvalid),
    .awready      (awready),
    .awaddr       (awaddr),
    .wvalid       (wvalid),
    .wready       (wready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .bvalid       (bvalid),
    .bready       (bready),
    .mem_arvalid  (mem_arvalid),
    .mem_arready  (mem_arready),
    .mem_araddr   (mem_araddr),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata),
    .mem_awvalid  (mem_awvalid),
    .mem_awready  (mem_awready),
    .mem_awaddr   (mem_awaddr),
    .mem_wvalid   (mem_wvalid),
    .mem_wready   (mem_wready),
    .mem_wdata    (mem_wdata),
    .mem_bvalid   (mem_bvalid),
    .lookup_addr  (lookup_addr),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_addr  (victim_addr),
    .line_data    (line_data),
    .fill_en      (fill_en),
    .fill_data    (fill_data),
    .write_en     (write_en),
    .write_data   (write_data),
    .write_strb   (write_strb)
  );

  cache_store u_store (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .lookup_addr  (lookup_addr),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_addr  (victim_addr),
    .line_data    (line_data),
    .fill_en      (fill_en),
    .fill_data    (fill_data),
    .write_en     (write_en),
    .wdata        (write_data),
    .wstrb        (write_strb)
  );

  backing_mem u_mem (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .mem_arvalid  (mem_arvalid),
    .mem_arready  (mem_arready),
    .mem_araddr   (mem_araddr),
    .mem_rvalid   (mem_rvalid),
    .mem_rdata    (mem_rdata),
    .mem_awvalid  (mem_awvalid),
    .mem_awready  (mem_awready),
    .mem_awaddr   (mem_awaddr),
    .mem_wvalid   (mem_wvalid),
    .mem_wready   (mem_wready),
    .mem_wdata    (mem_wdata),
    .mem_bvalid   (mem_bvalid)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vcache_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
echo "Pass message not found in the output"
exit 1

//--- sim/cache_checker.sv
`timescale 1ns/1ps

module cache_checker
  import axil_pkg::*;
(
  input logic  ACLK,
  input logic  ARESETn,
  input logic  arvalid,
  input logic  arready,
  input logic  awvalid,
  input logic  awready,
  input logic  wvalid,
  input logic  wready,
  input logic  rvalid,
  input logic  rready,
  input data_t rdata,
  input logic  bvalid,
  input logic  bready
);

  // A manager offers either a read or a write, never both
  read_write_apart: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(arvalid && (awvalid || wvalid)))
    else $error("arvalid raised in the same cycle as a write request");

  // Read response and its data held under back-pressure
  read_rsp_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else $error("rvalid or rdata changed before rready");

  write_rsp_held: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (bvalid && !bready) |=> bvalid)
    else $error("bvalid dropped before bready");

  // No new request while a response is pending
  busy_while_rsp: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (rvalid || bvalid) |-> !(arready || awready || wready))
    else $error("a ready signal was high while a response was pending");

endmodule

bind cache_top cache_checker u_checker (
  .ACLK    (ACLK),
  .ARESETn (ARESETn),
  .arvalid (arvalid),
  .arready (arready),
  .awvalid (awvalid),
  .awready (awready),
  .wvalid  (wvalid),
  .wready  (wready),
  .rvalid  (rvalid),
  .rready  (rready),
  .rdata   (rdata),
  .bvalid  (bvalid),
  .bready  (bready)
);

//--- sim/cache_tb.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb
  import axil_pkg::*;
();

  localparam int wait_limit = 100;
  localparam int model_aw = $clog2(`MEM_WORDS);

  logic  ACLK = 1'b0;
  logic  ARESETn;
  logic  arvalid;
  logic  arready;
  addr_t araddr;
  logic  rvalid;
  logic  rready;
  data_t rdata;
  logic  awvalid;
  logic  awready;
  addr_t awaddr;
  logic  wvalid;
  logic  wready;
  data_t wdata;
  strb_t wstrb;
  logic  bvalid;
  logic  bready;

  // Reference memory image and reads waiting for their response
  data_t  model_mem [`MEM_WORDS];
  data_t  exp_q [$];
  int     checks;
  int     errors;
  bit     hung;
  integer seed;

  cache_top uut (.*);

  always #50 ACLK = ~ACLK;

  function automatic data_t mem_model_read(addr_t addr);
    return model_mem[addr[`OFFSET_BITS +: model_aw]];
  endfunction

  // Only the lanes with a strobe take the new byte
  task automatic update_model(addr_t addr, data_t data, strb_t strb);
    data_t word;
    word = model_mem[addr[`OFFSET_BITS +: model_aw]];
    for (int b = 0; b < `STRB_W; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    model_mem[addr[`OFFSET_BITS +: model_aw]] = word;
  endtask

  task automatic check_bit(string name, logic got, logic expected);
    checks++;
    assert (got === expected) else begin
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, expected);
      errors++;
    end
  endtask

  task automatic check_word(string name, data_t got, data_t expected);
    checks++;
    assert (got === expected) else begin
      $display("Error: %s = 0x%08h, expected 0x%08h", name, got, expected);
      errors++;
    end
  endtask

  // A hit answers on the first cycle after acceptance, a miss later
  task automatic check_latency(addr_t addr, int lat, bit want_hit);
    checks++;
    assert ((lat == 1) == want_hit) else begin
      $display("Access at 0x%08h took %0d cycles, which is wrong for a %s", addr, lat,
               want_hit ? "hit" : "miss");
      errors++;
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timeout: %s", what);
    hung = 1'b1;
  endtask

  task automatic report_test(int num, string name, int err_before);
    if (errors == err_before && !hung) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      $display("Test %0d %s: failed", num, name);
    end
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic read_word(addr_t addr, int hold, output int lat);
    int    cnt;
    data_t held;
    lat = 0;
    if (hung) begin
      return;
    end
    rready  = (hold == 0);
    arvalid = 1'b1;
    araddr  = addr;
    cnt = 0;
    do begin
      @(negedge ACLK);
      cnt++;
    end while (!arready && cnt < wait_limit);
    if (!arready) begin
      report_timeout($sformatf("read request at 0x%08h was never accepted", addr));
      return;
    end
    exp_q.push_back(mem_model_read(addr));
    @(posedge ACLK);
    #1;
    arvalid = 1'b0;
    do begin
      @(negedge ACLK);
      lat++;
    end while (!rvalid && lat < wait_limit);
    if (!rvalid) begin
      report_timeout($sformatf("no read response for address 0x%08h", addr));
      return;
    end
    if (hold > 0) begin
      held = rdata;
      repeat (hold) begin
        @(negedge ACLK);
        check_bit("rvalid", rvalid, 1'b1);
        check_word("rdata", rdata, held);
        check_bit("arready", arready, 1'b0);
      end
      @(posedge ACLK);
      #1;
      rready = 1'b1;
    end
    // Response handshake on this edge
    @(posedge ACLK);
    #1;
  endtask

  task automatic write_word(addr_t addr, data_t data, strb_t strb, int hold,
                            output int lat);
    int cnt;
    lat = 0;
    if (hung) begin
      return;
    end
    bready  = (hold == 0);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    cnt = 0;
    do begin
      @(negedge ACLK);
      cnt++;
    end while (!(awready && wready) && cnt < wait_limit);
    if (!(awready && wready)) begin
      report_timeout($sformatf("write request at 0x%08h was never accepted", addr));
      return;
    end
    update_model(addr, data, strb);
    @(posedge ACLK);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    do begin
      @(negedge ACLK);
      lat++;
    end while (!bvalid && lat < wait_limit);
    if (!bvalid) begin
      report_timeout($sformatf("no write response for address 0x%08h", addr));
      return;
    end
    if (hold > 0) begin
      repeat (hold) begin
        @(negedge ACLK);
        check_bit("bvalid", bvalid, 1'b1);
        check_bit("awready", awready, 1'b0);
        check_bit("wready", wready, 1'b0);
      end
      @(posedge ACLK);
      #1;
      bready = 1'b1;
    end
    @(posedge ACLK);
    #1;
  endtask

  // Every completed read is compared with the model
  always @(negedge ACLK) begin
    data_t expected;
    if (ARESETn && rvalid && rready) begin
      checks++;
      assert (exp_q.size() > 0) else begin
        $display("A read response arrived with no read outstanding");
        errors++;
      end
      if (exp_q.size() > 0) begin
        expected = exp_q.pop_front();
        assert (rdata === expected) else begin
          $display("Error: rdata = 0x%08h, expected 0x%08h", rdata, expected);
          errors++;
        end
      end
    end
  end

  initial begin
    addr_t       addr;
    data_t       data;
    logic [31:0] rnd;
    int          lat;
    int          err_before;

    seed    = 32'hc8fb4c99;
    checks  = 0;
    errors  = 0;
    hung    = 1'b0;
    ARESETn = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b1;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b1;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end

    repeat (2) @(posedge ACLK);
    #1;
    ARESETn = 1'b1;

    err_before = errors;
    @(negedge ACLK);
    check_bit("arready", arready, 1'b1);
    check_bit("awready", awready, 1'b1);
    check_bit("wready", wready, 1'b1);
    check_bit("rvalid", rvalid, 1'b0);
    check_bit("bvalid", bvalid, 1'b0);
    @(posedge ACLK);
    #1;
    report_test(1, "reset state", err_before);

    err_before = errors;
    read_word(32'h40, 0, lat);
    write_word(32'h44, 32'hdead_beef, 4'hf, 0, lat);
    read_word(32'h44, 0, lat);
    read_word(32'h44, 0, lat);
    check_latency(32'h44, lat, 1'b1);
    report_test(2, "read and write basics", err_before);

    // Partial write on a hit, then on a miss after the line was evicted
    err_before = errors;
    write_word(32'h48, 32'h1122_3344, 4'hf, 0, lat);
    write_word(32'h48, 32'haabb_ccdd, 4'b0101, 0, lat);
    check_latency(32'h48, lat, 1'b1);
    read_word(32'h48, 0, lat);
    write_word(32'h4c, 32'h5566_7788, 4'hf, 0, lat);
    write_word(32'h8c, 32'h99aa_bbcc, 4'hf, 0, lat);
    write_word(32'h4c, 32'heeff_0011, 4'b1010, 0, lat);
    check_latency(32'h4c, lat, 1'b0);
    read_word(32'h4c, 0, lat);
    report_test(3, "partial strobes", err_before);

    // Same index, different tags
    err_before = errors;
    write_word(32'h50, 32'h0bad_f00d, 4'hf, 0, lat);
    write_word(32'h90, 32'h600d_cafe, 4'hf, 0, lat);
    check_latency(32'h90, lat, 1'b0);
    read_word(32'h50, 0, lat);
    check_latency(32'h50, lat, 1'b0);
    read_word(32'h90, 0, lat);
    report_test(4, "dirty writeback and refill", err_before);

    err_before = errors;
    read_word(32'h44, 4, lat);
    read_word(32'h48, 0, lat);
    write_word(32'h54, 32'h1357_9bdf, 4'hf, 4, lat);
    read_word(32'h54, 0, lat);
    report_test(5, "response back-pressure", err_before);

    // Sixteen words, spanning four tags in every set
    err_before = errors;
    for (int i = 0; i < 40; i++) begin
      rnd  = $random(seed);
      addr = 32'h100 + {26'd0, rnd[3:0], 2'b00};
      if (rnd[4]) begin
        data = $random(seed);
        write_word(addr, data, rnd[11:8], 0, lat);
      end else begin
        read_word(addr, 0, lat);
      end
    end
    report_test(6, "random traffic", err_before);

    if (!hung) begin
      checks++;
      assert (exp_q.size() == 0) else begin
        $display("%0d read responses never reached the compare process", exp_q.size());
        errors++;
      end
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, hung);
    if (errors == 0 && !hung) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
logic/axil_pkg.sv
logic/cache_pkg.sv
logic/cache_store.sv
logic/cache_ctrl.sv
logic/backing_mem.sv
logic/cache_top.sv
sim/cache_checker.sv
sim/cache_tb.sv
